// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tpm_reg_space
FILELIST  = tpm_reg_space.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/tpm_interrupt_ctrl.sv ====
// Interrupt registers and PIRQ
`timescale 1ns/1ps

module tpm_interrupt_ctrl
(
	input  logic       clock,
	input  logic       reset_n,
	input  logic       advance_i,
	input  logic [1:0] int_enable_wr_i, // Lane 0 is byte 0, lane 1 is byte 3
	input  logic       int_vector_wr_i,
	input  logic       int_status_wr_i,
	input  logic [7:0] wdata_i,
	input  logic       command_ready_i,
	input  logic       data_avail_i,
	input  logic       loc_changed_i,
	output logic       global_en_o,
	output logic [7:0] enable_o,
	output logic [3:0] vector_o,
	output logic [7:0] status_o,
	output logic       pirq_n_o
);

	logic       cmd_ready_en;
	logic [1:0] polarity;
	logic       loc_change_en;
	logic       data_avail_en;
	logic       cmd_ready_d;
	logic       data_avail_d;
	logic       st_cmd_ready;
	logic       st_loc_change;
	logic       st_data_avail;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			global_en_o <= 1'b0;
			cmd_ready_en <= 1'b0;
			polarity <= 2'b01;
			loc_change_en <= 1'b0;
			data_avail_en <= 1'b0;
			vector_o <= '0;
		end
		else
		begin
			if (int_enable_wr_i[0])
			begin
				cmd_ready_en <= wdata_i[7];
				polarity <= wdata_i[4:3];
				loc_change_en <= wdata_i[2];
				data_avail_en <= wdata_i[0];
			end
			if (int_enable_wr_i[1])
				global_en_o <= wdata_i[7];
			if (int_vector_wr_i)
				vector_o <= wdata_i[3:0];
		end
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_ready_d <= 1'b0;
			data_avail_d <= 1'b0;
			st_cmd_ready <= 1'b0;
			st_loc_change <= 1'b0;
			st_data_avail <= 1'b0;
		end
		else if (int_status_wr_i)
		begin
			// Write one to clear
			st_cmd_ready <= st_cmd_ready & ~wdata_i[7];
			st_loc_change <= st_loc_change & ~wdata_i[2];
			st_data_avail <= st_data_avail & ~wdata_i[0];
		end
		else if (advance_i)
		begin
			cmd_ready_d <= command_ready_i;
			data_avail_d <= data_avail_i;
			if (global_en_o && cmd_ready_en && command_ready_i && !cmd_ready_d)
				st_cmd_ready <= 1'b1;
			if (global_en_o && data_avail_en && data_avail_i && !data_avail_d)
				st_data_avail <= 1'b1;
			if (global_en_o && loc_change_en && loc_changed_i)
				st_loc_change <= 1'b1;
		end
	end

	// stsValid interrupt is not supported, its bit stays clear
	assign enable_o = {cmd_ready_en, 2'b00, polarity, loc_change_en, 1'b0, data_avail_en};
	assign status_o = {st_cmd_ready, 4'h0, st_loc_change, 1'b0, st_data_avail};
	assign pirq_n_o = ~|status_o;

endmodule

// ==== source/tpm_locality_arbiter.sv ====
// Locality arbitration
`timescale 1ns/1ps

module tpm_locality_arbiter
#(
	parameter int num_localities = 5
)
(
	input  logic       clock,
	input  logic       reset_n,
	input  logic       advance_i,
	input  logic       access_wr_i,
	input  logic [3:0] access_loc_i,
	input  logic [7:0] wdata_i,
	output logic [7:0] locality_o,    // One-hot grant
	output logic [3:0] active_loc_o,
	output logic       grant_valid_o,
	output logic       been_seized_o,
	output logic       request_use_o,
	output logic       pending_o,
	output logic       changed_o,
	output logic       seize_o
);

	tpm_pkg::loc_state_t state_q;
	logic [3:0] active_q;

	logic [num_localities-1:0] request_q;
	logic [num_localities-1:0] seize_q;
	logic [num_localities-1:0] relinquish_q;
	logic [num_localities-1:0] been_seized_q;

	// Widened so any 4-bit locality can index them
	logic [15:0] request_ext;
	logic [15:0] relinquish_ext;
	logic [15:0] been_seized_ext;

	logic [3:0] high_req;
	logic       req_found;
	logic [3:0] high_seize;
	logic       seize_found;
	logic       take_seize;

	assign request_ext     = 16'(request_q);
	assign relinquish_ext  = 16'(relinquish_q);
	assign been_seized_ext = 16'(been_seized_q);

	// Highest index wins
	always_comb
	begin
		high_req = '0;
		req_found = 1'b0;
		high_seize = '0;
		seize_found = 1'b0;
		for (int i = 0; i < num_localities; i++)
		begin
			if (request_q[i])
			begin
				high_req = 4'(i);
				req_found = 1'b1;
			end
			if (seize_q[i])
			begin
				high_seize = 4'(i);
				seize_found = 1'b1;
			end
		end
	end

	// Lower localities cannot seize
	assign take_seize = (state_q == tpm_pkg::loc_grant) && seize_found && (high_seize > active_q);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			request_q <= '0;
			seize_q <= '0;
			relinquish_q <= '0;
			been_seized_q <= '0;
		end
		else
		begin
			for (int i = 0; i < num_localities; i++)
			begin
				if (access_wr_i && access_loc_i == 4'(i))
				begin
					request_q[i] <= wdata_i[tpm_pkg::access_request_bit] |
						wdata_i[tpm_pkg::access_seize_bit]; // Seize implies a request
					seize_q[i] <= wdata_i[tpm_pkg::access_seize_bit];
					relinquish_q[i] <= wdata_i[tpm_pkg::access_relinquish_bit];
					if (wdata_i[tpm_pkg::access_clear_seized_bit])
						been_seized_q[i] <= 1'b0;
				end
				else if (advance_i)
				begin
					seize_q[i] <= 1'b0;       // Seize and relinquish last one step
					relinquish_q[i] <= 1'b0;
					if (take_seize && active_q == 4'(i))
						been_seized_q[i] <= 1'b1;
					if (state_q == tpm_pkg::loc_release && req_found && high_req == 4'(i))
						request_q[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state_q <= tpm_pkg::loc_null;
			active_q <= '0;
		end
		else if (advance_i)
		begin
			if (take_seize)
				state_q <= tpm_pkg::loc_release;
			else
			begin
				case (state_q)
					tpm_pkg::loc_null:
						if (req_found)
							state_q <= tpm_pkg::loc_release;
					tpm_pkg::loc_release:
						if (req_found)
						begin
							state_q <= tpm_pkg::loc_grant;
							active_q <= high_req;
						end
						else
							state_q <= tpm_pkg::loc_null;
					tpm_pkg::loc_grant:
						if (relinquish_ext[active_q])
							state_q <= tpm_pkg::loc_release;
					default:
						state_q <= tpm_pkg::loc_null;
				endcase
			end
		end
	end

	assign grant_valid_o = (state_q == tpm_pkg::loc_grant);
	assign locality_o    = grant_valid_o ? (8'h01 << active_q) : 8'h00;
	assign active_loc_o  = active_q;
	assign changed_o     = (state_q == tpm_pkg::loc_release);
	assign seize_o       = advance_i & take_seize;

	// Access register fields of the addressed locality
	assign been_seized_o = been_seized_ext[access_loc_i];
	assign request_use_o = request_ext[access_loc_i];
	assign pending_o     = |request_q;

endmodule

// ==== source/tpm_pkg.sv ====
// TPM register space definitions
package tpm_pkg;

	// Address split: locality in 15:12, register offset below
	typedef logic [15:0] addr_t;
	typedef logic [3:0]  loc_field_t;
	typedef logic [11:0] offset_t;

	// Register offsets, first byte of each register
	localparam offset_t access_ofs       = 12'h000;
	localparam offset_t int_enable_ofs   = 12'h008;
	localparam offset_t int_vector_ofs   = 12'h00C;
	localparam offset_t int_status_ofs   = 12'h010;
	localparam offset_t intf_cap_ofs     = 12'h014;
	localparam offset_t sts_ofs          = 12'h018;
	localparam offset_t interface_id_ofs = 12'h030;
	localparam offset_t did_vid_ofs      = 12'hF00;
	localparam offset_t rid_ofs          = 12'hF04;

	// Both FIFO windows are four bytes wide
	localparam offset_t fifo_lo_ofs = 12'h024;
	localparam offset_t fifo_hi_ofs = 12'h080;

	typedef enum logic [2:0] {
		loc_null,
		loc_release,
		loc_grant
	} loc_state_t;

	typedef enum logic [2:0] {
		sts_idle,
		sts_ready,
		sts_reception,
		sts_execution,
		sts_completion
	} sts_state_t;

	// TPM_ACCESS write bits
	localparam int access_request_bit      = 1;
	localparam int access_seize_bit        = 3;
	localparam int access_clear_seized_bit = 4;
	localparam int access_relinquish_bit   = 5;

	// TPM_STS write bits
	localparam int sts_go_bit            = 5;
	localparam int sts_command_ready_bit = 6;

	localparam logic [15:0] burst_count = 16'h0064;
	localparam logic [1:0]  tpm_family  = 2'b01; // TPM 2.0

	// TPM_INTF_CAPABILITY, byte 2 reads zero
	localparam logic [7:0] intf_cap_b0 = 8'hD5; // Falling edge and low level, no stsValid
	localparam logic [7:0] intf_cap_b1 = 8'h07; // 64 byte transfers, static burst count
	localparam logic [7:0] intf_cap_b3 = 8'h30; // Interface version 1.3

	localparam logic [7:0] intf_id_b1     = 8'h01; // Localities supported
	localparam logic [7:0] rid_value      = 8'hFF;
	localparam logic [7:0] idle_read_byte = 8'hFF;

endpackage

// ==== source/tpm_reg_decode.sv ====
// Register decode and read mux
`timescale 1ns/1ps

module tpm_reg_decode
#(
	parameter int          num_localities = 5,
	parameter logic [15:0] did_value      = 16'h5654,
	parameter logic [15:0] vid_value      = 16'h3037
)
(
	input  logic                 clock,
	input  logic                 reset_n,
	input  logic                 req_i,
	input  logic                 dir_i,
	input  tpm_pkg::addr_t       addr_i,
	input  logic [7:0]           wdata_i,
	input  logic [7:0]           fifo_byte_i,
	input  tpm_pkg::loc_field_t  active_loc_i,
	input  logic                 grant_valid_i,
	input  logic                 been_seized_i,
	input  logic                 request_use_i,
	input  logic                 pending_i,
	input  logic                 command_ready_i,
	input  logic                 go_i,
	input  logic                 data_avail_i,
	input  logic                 expect_i,
	input  logic                 global_en_i,
	input  logic [7:0]           enable_i,
	input  logic [3:0]           vector_i,
	input  logic [7:0]           int_status_i,
	output logic [7:0]           read_byte_o,
	output logic                 fifo_read_o,
	output logic                 fifo_write_o,
	output logic                 advance_o,
	output logic                 access_wr_o,
	output tpm_pkg::loc_field_t  access_loc_o,
	output logic                 sts_wr_o,
	output logic [1:0]           int_enable_wr_o,
	output logic                 int_vector_wr_o,
	output logic                 int_status_wr_o
);

	tpm_pkg::loc_field_t loc_field;
	tpm_pkg::offset_t    offset;
	logic       fifo_hit;
	logic       loc_match;
	logic       loc_exists;
	logic       reg_wr;
	logic       sel_wr;
	logic [7:0] access_byte;
	logic [7:0] reg_byte;
	logic       sel_lock_q;
	logic [1:0] selector_q;

	assign loc_field  = addr_i[15:12];
	assign offset     = addr_i[11:0];
	assign fifo_hit   = (offset[11:2] == tpm_pkg::fifo_lo_ofs[11:2]) ||
		(offset[11:2] == tpm_pkg::fifo_hi_ofs[11:2]);
	assign loc_match  = grant_valid_i && (loc_field == active_loc_i);
	assign loc_exists = int'(loc_field) < num_localities;

	// State machines step while the port is idle or in the FIFO window
	assign advance_o    = ~req_i | fifo_hit;
	assign fifo_read_o  = req_i & fifo_hit & dir_i & loc_match;
	assign fifo_write_o = req_i & fifo_hit & ~dir_i & loc_match & expect_i;

	// Access register is open to every locality
	assign access_wr_o  = req_i & ~dir_i & (offset == tpm_pkg::access_ofs) & loc_exists;
	assign access_loc_o = loc_field;

	assign reg_wr          = req_i & ~dir_i & ~fifo_hit & loc_match;
	assign sts_wr_o        = reg_wr & (offset == tpm_pkg::sts_ofs);
	assign int_enable_wr_o = {reg_wr & (offset == tpm_pkg::int_enable_ofs + 12'd3),
		reg_wr & (offset == tpm_pkg::int_enable_ofs)};
	assign int_vector_wr_o = reg_wr & (offset == tpm_pkg::int_vector_ofs);
	assign int_status_wr_o = reg_wr & (offset == tpm_pkg::int_status_ofs);
	assign sel_wr          = reg_wr & (offset == tpm_pkg::interface_id_ofs + 12'd2);

	// Valid, active, seized, pending, requested, established
	assign access_byte = {1'b1, 1'b0, loc_match, been_seized_i, 1'b0, pending_i,
		request_use_i, 1'b1};

	always_comb
	begin
		case (offset)
			tpm_pkg::int_enable_ofs:             reg_byte = enable_i;
			tpm_pkg::int_enable_ofs + 12'd3:     reg_byte = {global_en_i, 7'h00};
			tpm_pkg::int_vector_ofs:             reg_byte = {4'h0, vector_i};
			tpm_pkg::int_status_ofs:             reg_byte = int_status_i;
			tpm_pkg::intf_cap_ofs:               reg_byte = tpm_pkg::intf_cap_b0;
			tpm_pkg::intf_cap_ofs + 12'd1:       reg_byte = tpm_pkg::intf_cap_b1;
			tpm_pkg::intf_cap_ofs + 12'd3:       reg_byte = tpm_pkg::intf_cap_b3;
			tpm_pkg::sts_ofs:                    reg_byte = {1'b1, command_ready_i, go_i,
				data_avail_i, expect_i, 3'b000};
			tpm_pkg::sts_ofs + 12'd1:            reg_byte = tpm_pkg::burst_count[7:0];
			tpm_pkg::sts_ofs + 12'd2:            reg_byte = tpm_pkg::burst_count[15:8];
			tpm_pkg::sts_ofs + 12'd3:            reg_byte = {4'h0, tpm_pkg::tpm_family, 2'b00};
			tpm_pkg::interface_id_ofs + 12'd1:   reg_byte = tpm_pkg::intf_id_b1;
			tpm_pkg::interface_id_ofs + 12'd2:   reg_byte = {4'h0, sel_lock_q, selector_q, 1'b0};
			tpm_pkg::did_vid_ofs:                reg_byte = vid_value[7:0];
			tpm_pkg::did_vid_ofs + 12'd1:        reg_byte = vid_value[15:8];
			tpm_pkg::did_vid_ofs + 12'd2:        reg_byte = did_value[7:0];
			tpm_pkg::did_vid_ofs + 12'd3:        reg_byte = did_value[15:8];
			tpm_pkg::rid_ofs:                    reg_byte = tpm_pkg::rid_value;
			// Reserved upper bytes of mapped registers
			tpm_pkg::int_enable_ofs + 12'd1, tpm_pkg::int_enable_ofs + 12'd2,
			tpm_pkg::int_status_ofs + 12'd1, tpm_pkg::int_status_ofs + 12'd2,
			tpm_pkg::int_status_ofs + 12'd3, tpm_pkg::intf_cap_ofs + 12'd2,
			tpm_pkg::interface_id_ofs, tpm_pkg::interface_id_ofs + 12'd3:
				reg_byte = 8'h00;
			default:                             reg_byte = tpm_pkg::idle_read_byte;
		endcase
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			read_byte_o <= tpm_pkg::idle_read_byte;
		else if (req_i)
		begin
			if (fifo_hit)
				read_byte_o <= loc_match ? fifo_byte_i : tpm_pkg::idle_read_byte;
			else if (offset == tpm_pkg::access_ofs)
				read_byte_o <= loc_exists ? access_byte : tpm_pkg::idle_read_byte;
			else if (loc_match)
				read_byte_o <= reg_byte;
			else
				read_byte_o <= tpm_pkg::idle_read_byte;
		end
	end

	// Interface selector, frozen once the lock bit is written
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			sel_lock_q <= 1'b0;
			selector_q <= 2'b11;
		end
		else if (sel_wr)
		begin
			sel_lock_q <= sel_lock_q | wdata_i[3];
			if (!sel_lock_q)
				selector_q <= wdata_i[2:1];
		end
	end

endmodule

// ==== source/tpm_reg_space.sv ====
// TPM FIFO register space top
`timescale 1ns/1ps

module tpm_reg_space
#(
	parameter int          num_localities = 5,
	parameter logic [15:0] did_value      = 16'h5654,
	parameter logic [15:0] vid_value      = 16'h3037
)
(
	input  logic        clock,
	input  logic        reset_n,
	input  logic        req_i,
	input  logic        dir_i,           // 1 = read
	input  logic [15:0] addr_i,
	input  logic [7:0]  wdata_i,
	input  logic [7:0]  fifo_byte_i,
	input  logic        fifo_complete_i,
	input  logic        fifo_empty_i,
	input  logic        exec_done_i,
	output logic [7:0]  read_byte_o,
	output logic [7:0]  locality_o,
	output logic        pirq_n_o,
	output logic        fifo_read_o,
	output logic        fifo_write_o
);

	logic       advance;
	logic       access_wr;
	logic [3:0] access_loc;
	logic       sts_wr;
	logic [1:0] int_enable_wr;
	logic       int_vector_wr;
	logic       int_status_wr;

	logic [3:0] active_loc;
	logic       grant_valid;
	logic       been_seized;
	logic       request_use;
	logic       pending;
	logic       loc_changed;
	logic       seize;

	logic       command_ready;
	logic       go;
	logic       data_avail;
	logic       expect_data;

	logic       global_en;
	logic [7:0] int_enable;
	logic [3:0] int_vector;
	logic [7:0] int_status;

	tpm_reg_decode #(
		.num_localities(num_localities),
		.did_value     (did_value),
		.vid_value     (vid_value)
	) u_decode (
		.clock          (clock),
		.reset_n        (reset_n),
		.req_i          (req_i),
		.dir_i          (dir_i),
		.addr_i         (addr_i),
		.wdata_i        (wdata_i),
		.fifo_byte_i    (fifo_byte_i),
		.active_loc_i   (active_loc),
		.grant_valid_i  (grant_valid),
		.been_seized_i  (been_seized),
		.request_use_i  (request_use),
		.pending_i      (pending),
		.command_ready_i(command_ready),
		.go_i           (go),
		.data_avail_i   (data_avail),
		.expect_i       (expect_data),
		.global_en_i    (global_en),
		.enable_i       (int_enable),
		.vector_i       (int_vector),
		.int_status_i   (int_status),
		.read_byte_o    (read_byte_o),
		.fifo_read_o    (fifo_read_o),
		.fifo_write_o   (fifo_write_o),
		.advance_o      (advance),
		.access_wr_o    (access_wr),
		.access_loc_o   (access_loc),
		.sts_wr_o       (sts_wr),
		.int_enable_wr_o(int_enable_wr),
		.int_vector_wr_o(int_vector_wr),
		.int_status_wr_o(int_status_wr)
	);

	tpm_locality_arbiter #(
		.num_localities(num_localities)
	) u_locality (
		.clock        (clock),
		.reset_n      (reset_n),
		.advance_i    (advance),
		.access_wr_i  (access_wr),
		.access_loc_i (access_loc),
		.wdata_i      (wdata_i),
		.locality_o   (locality_o),
		.active_loc_o (active_loc),
		.grant_valid_o(grant_valid),
		.been_seized_o(been_seized),
		.request_use_o(request_use),
		.pending_o    (pending),
		.changed_o    (loc_changed),
		.seize_o      (seize)
	);

	tpm_status_fsm u_status (
		.clock          (clock),
		.reset_n        (reset_n),
		.advance_i      (advance),
		.sts_wr_i       (sts_wr),
		.wdata_i        (wdata_i),
		.fifo_write_i   (fifo_write_o),
		.fifo_complete_i(fifo_complete_i),
		.fifo_empty_i   (fifo_empty_i),
		.exec_done_i    (exec_done_i),
		.seize_i        (seize),
		.command_ready_o(command_ready),
		.go_o           (go),
		.data_avail_o   (data_avail),
		.expect_o       (expect_data)
	);

	tpm_interrupt_ctrl u_interrupt (
		.clock          (clock),
		.reset_n        (reset_n),
		.advance_i      (advance),
		.int_enable_wr_i(int_enable_wr),
		.int_vector_wr_i(int_vector_wr),
		.int_status_wr_i(int_status_wr),
		.wdata_i        (wdata_i),
		.command_ready_i(command_ready),
		.data_avail_i   (data_avail),
		.loc_changed_i  (loc_changed),
		.global_en_o    (global_en),
		.enable_o       (int_enable),
		.vector_o       (int_vector),
		.status_o       (int_status),
		.pirq_n_o       (pirq_n_o)
	);

endmodule

// ==== source/tpm_status_fsm.sv ====
// TPM_STS command state machine
`timescale 1ns/1ps

module tpm_status_fsm
(
	input  logic       clock,
	input  logic       reset_n,
	input  logic       advance_i,
	input  logic       sts_wr_i,
	input  logic [7:0] wdata_i,
	input  logic       fifo_write_i,
	input  logic       fifo_complete_i,
	input  logic       fifo_empty_i,
	input  logic       exec_done_i,
	input  logic       seize_i,
	output logic       command_ready_o,
	output logic       go_o,
	output logic       data_avail_o,
	output logic       expect_o
);

	tpm_pkg::sts_state_t state_q;
	tpm_pkg::sts_state_t state_next;
	logic cmd_ready_req;
	logic go_req;

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			tpm_pkg::sts_idle:
				if (cmd_ready_req)
					state_next = tpm_pkg::sts_ready;
			tpm_pkg::sts_ready:
				if (fifo_write_i)
					state_next = tpm_pkg::sts_reception;
			tpm_pkg::sts_reception:
				if (cmd_ready_req)
					state_next = tpm_pkg::sts_idle;
				else if (go_req && fifo_complete_i)
					state_next = tpm_pkg::sts_execution;
			tpm_pkg::sts_execution:
				if (cmd_ready_req)
					state_next = tpm_pkg::sts_idle;
				else if (exec_done_i)
					state_next = tpm_pkg::sts_completion;
			tpm_pkg::sts_completion:
				if (cmd_ready_req)
					state_next = tpm_pkg::sts_idle;
			default:
				state_next = tpm_pkg::sts_idle;
		endcase
		if (seize_i)
			state_next = tpm_pkg::sts_idle; // Aborts any command
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state_q <= tpm_pkg::sts_idle;
			cmd_ready_req <= 1'b0;
			go_req <= 1'b0;
			command_ready_o <= 1'b0;
			data_avail_o <= 1'b0;
			expect_o <= 1'b0;
		end
		else if (sts_wr_i)
		begin
			cmd_ready_req <= wdata_i[tpm_pkg::sts_command_ready_bit];
			go_req <= wdata_i[tpm_pkg::sts_go_bit];
		end
		else if (advance_i)
		begin
			state_q <= state_next;
			cmd_ready_req <= 1'b0;
			go_req <= 1'b0;
			command_ready_o <= (state_next == tpm_pkg::sts_ready);
			// Ready already takes the first command byte
			expect_o <= (state_next == tpm_pkg::sts_ready) ||
				(state_next == tpm_pkg::sts_reception && !fifo_complete_i);
			data_avail_o <= (state_next == tpm_pkg::sts_completion) && !fifo_empty_i;
		end
	end

	assign go_o = go_req;

endmodule

// ==== testbench/tb_tpm_reg_space.sv ====
// TPM register space testbench
`timescale 1ns/1ps

module tb_tpm_reg_space;

	localparam logic [15:0] did_value = 16'h5654;
	localparam logic [15:0] vid_value = 16'h3037;
	localparam int timeout_cycles = 200;

	logic        clock;
	logic        reset_n;
	logic        req;
	logic        dir;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic [7:0]  fifo_byte;
	logic        fifo_complete;
	logic        fifo_empty;
	logic        exec_done;
	logic [7:0]  read_byte;
	logic [7:0]  locality;
	logic        pirq_n;
	logic        fifo_read;
	logic        fifo_write;

	int          error_count;
	int          check_count;
	logic [31:0] lcg_state;
	logic        seen_fifo_write; // Strobes sampled inside the request cycle
	logic        seen_fifo_read;

	tpm_reg_space #(
		.num_localities(5),
		.did_value     (did_value),
		.vid_value     (vid_value)
	) u_dut (
		.clock          (clock),
		.reset_n        (reset_n),
		.req_i          (req),
		.dir_i          (dir),
		.addr_i         (addr),
		.wdata_i        (wdata),
		.fifo_byte_i    (fifo_byte),
		.fifo_complete_i(fifo_complete),
		.fifo_empty_i   (fifo_empty),
		.exec_done_i    (exec_done),
		.read_byte_o    (read_byte),
		.locality_o     (locality),
		.pirq_n_o       (pirq_n),
		.fifo_read_o    (fifo_read),
		.fifo_write_o   (fifo_write)
	);

	always #4 clock = ~clock;

	function automatic logic [7:0] random_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// TPM_ACCESS layout: valid, active, beenSeized, pending, requestUse, establishment
	function automatic logic [7:0] access_value(input logic active, input logic seized,
		input logic pending, input logic requested);
		return {1'b1, 1'b0, active, seized, 1'b0, pending, requested, 1'b1};
	endfunction

	// TPM_STS byte 0 with stsValid always set
	function automatic logic [7:0] sts_value(input logic cmd_ready, input logic go,
		input logic avail, input logic expect_bit);
		return {1'b1, cmd_ready, go, avail, expect_bit, 3'b000};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic reg_write(input logic [15:0] address, input logic [7:0] data);
		@(negedge clock);
		req = 1'b1;
		dir = 1'b0;
		addr = address;
		wdata = data;
		#1;
		seen_fifo_write = fifo_write;
		seen_fifo_read = fifo_read;
		@(negedge clock);
		req = 1'b0;
	endtask

	task automatic reg_read(input logic [15:0] address, output logic [7:0] data);
		@(negedge clock);
		req = 1'b1;
		dir = 1'b1;
		addr = address;
		#1;
		seen_fifo_write = fifo_write;
		seen_fifo_read = fifo_read;
		@(negedge clock);
		req = 1'b0;
		data = read_byte; // Registered on the edge of the request
	endtask

	task automatic read_check(input logic [15:0] address, input logic [7:0] expected,
		input string name);
		logic [7:0] data;
		reg_read(address, data);
		check_value(name, 32'(data), 32'(expected));
	endtask

	// Polls a register until the masked bits match
	task automatic wait_reg(input logic [15:0] address, input logic [7:0] mask,
		input logic [7:0] value, input string name);
		logic [7:0] data;
		int count;
		count = 0;
		reg_read(address, data);
		while (((data & mask) != value) && count < timeout_cycles)
		begin
			reg_read(address, data);
			count++;
		end
		if ((data & mask) != value)
			$display("Timed out at %0t ns waiting for %s to change", $time, name);
		check_value(name, 32'(data & mask), 32'(value));
	endtask

	task automatic wait_locality(input logic [7:0] expected);
		int count;
		count = 0;
		@(negedge clock);
		while (locality != expected && count < timeout_cycles)
		begin
			@(negedge clock);
			count++;
		end
		if (locality != expected)
			$display("Timed out at %0t ns waiting for a locality grant", $time);
		check_value("locality_o", 32'(locality), 32'(expected));
	endtask

	task automatic wait_pirq(input logic expected);
		int count;
		count = 0;
		@(negedge clock);
		while (pirq_n != expected && count < timeout_cycles)
		begin
			@(negedge clock);
			count++;
		end
		if (pirq_n != expected)
			$display("Timed out at %0t ns waiting for the interrupt line", $time);
		check_value("pirq_n_o", 32'(pirq_n), 32'(expected));
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s finished with %0d errors", name, error_count - errors_before);
	endtask

	task automatic identity_test();
		int errors_before;
		errors_before = error_count;
		check_value("locality_o", 32'(locality), 32'h00);
		check_value("pirq_n_o", 32'(pirq_n), 32'h1);
		check_value("read_byte_o", 32'(read_byte), 32'hFF);
		check_value("fifo_read_o", 32'(fifo_read), 32'h0);
		check_value("fifo_write_o", 32'(fifo_write), 32'h0);
		read_check(16'h0F00, 8'hFF, "did_vid without grant");
		read_check(16'h0000, access_value(0, 0, 0, 0), "access loc0");
		reg_write(16'h0000, 8'h02); // Request locality 0
		wait_locality(8'h01);
		read_check(16'h0F00, vid_value[7:0], "vid low");
		read_check(16'h0F01, vid_value[15:8], "vid high");
		read_check(16'h0F02, did_value[7:0], "did low");
		read_check(16'h0F03, did_value[15:8], "did high");
		read_check(16'h0F04, tpm_pkg::rid_value, "rid");
		read_check(16'h0014, tpm_pkg::intf_cap_b0, "intf_cap byte 0");
		read_check(16'h0015, tpm_pkg::intf_cap_b1, "intf_cap byte 1");
		read_check(16'h0016, 8'h00, "intf_cap byte 2");
		read_check(16'h0017, tpm_pkg::intf_cap_b3, "intf_cap byte 3");
		read_check(16'h0019, tpm_pkg::burst_count[7:0], "burst count low");
		read_check(16'h001A, tpm_pkg::burst_count[15:8], "burst count high");
		read_check(16'h001B, {4'h0, tpm_pkg::tpm_family, 2'b00}, "tpm family");
		read_check(16'h0031, tpm_pkg::intf_id_b1, "interface id byte 1");
		read_check(16'h0032, 8'h06, "interface selector"); // Selector resets to 2'b11
		read_check(16'h0000, access_value(1, 0, 0, 0), "access loc0 granted");
		report_test("identity", errors_before);
	endtask

	task automatic arbitration_test();
		int errors_before;
		logic [7:0] data;
		errors_before = error_count;
		reg_write(16'h1000, 8'h02);
		reg_write(16'h3000, 8'h02);
		read_check(16'h0000, access_value(1, 0, 1, 0), "access loc0 pending");
		reg_write(16'h0000, 8'h20); // Relinquish, highest requester wins
		wait_locality(8'h08);
		reg_write(16'h3000, 8'h20);
		wait_locality(8'h02);
		reg_write(16'h4000, 8'h08); // Seize from above
		wait_locality(8'h10);
		read_check(16'h1000, access_value(0, 1, 0, 0), "access loc1 seized");
		reg_write(16'h1000, 8'h10); // Clear beenSeized
		read_check(16'h1000, access_value(0, 0, 0, 0), "access loc1 cleared");
		read_check(16'h1F00, 8'hFF, "did_vid loc1");
		read_check(16'h1018, 8'hFF, "sts loc1");
		reg_read(16'h1024, data);
		check_value("fifo read loc1", 32'(data), 32'hFF);
		check_value("fifo_read_o", 32'(seen_fifo_read), 32'h0);
		reg_write(16'h1018, 8'h40); // Must not reach the status FSM
		report_test("arbitration", errors_before);
	endtask

	task automatic command_test();
		int errors_before;
		logic [7:0] data;
		logic [7:0] sent;
		errors_before = error_count;
		read_check(16'h4018, sts_value(0, 0, 0, 0), "sts idle");
		reg_write(16'h4018, 8'h40);
		wait_reg(16'h4018, 8'h40, 8'h40, "sts commandReady");
		sent = random_byte();
		reg_write(16'h4024, sent);
		check_value("fifo_write_o", 32'(seen_fifo_write), 32'h1);
		wait_reg(16'h4018, 8'h48, 8'h08, "sts expect"); // Reception
		@(negedge clock);
		fifo_complete = 1'b1;
		reg_write(16'h4018, 8'h20); // tpmGo
		wait_reg(16'h4018, 8'h08, 8'h00, "sts expect clear");
		@(negedge clock);
		exec_done = 1'b1;
		fifo_empty = 1'b0;
		wait_reg(16'h4018, 8'h10, 8'h10, "sts dataAvail");
		fifo_byte = random_byte();
		reg_read(16'h4024, data);
		check_value("fifo read byte", 32'(data), 32'(fifo_byte));
		check_value("fifo_read_o", 32'(seen_fifo_read), 32'h1);
		reg_write(16'h4024, sent);
		check_value("fifo_write_o no expect", 32'(seen_fifo_write), 32'h0);
		@(negedge clock);
		exec_done = 1'b0;
		fifo_complete = 1'b0;
		fifo_empty = 1'b1;
		reg_write(16'h4018, 8'h40); // Back to Idle
		wait_reg(16'h4018, 8'hFF, sts_value(0, 0, 0, 0), "sts back to idle");
		report_test("command", errors_before);
	endtask

	task automatic interrupt_test();
		int errors_before;
		logic [3:0] vector;
		errors_before = error_count;
		vector = 4'(random_byte());
		reg_write(16'h400C, {4'h0, vector});
		read_check(16'h400C, {4'h0, vector}, "int_vector");
		reg_write(16'h4008, 8'h88); // commandReady enable, low level polarity
		reg_write(16'h400B, 8'h80); // Global enable
		read_check(16'h4008, 8'h88, "int_enable byte 0");
		read_check(16'h400B, 8'h80, "int_enable byte 3");
		check_value("pirq_n_o", 32'(pirq_n), 32'h1);
		reg_write(16'h4018, 8'h40);
		wait_pirq(1'b0);
		read_check(16'h4010, 8'h80, "int_status set");
		reg_write(16'h4010, 8'h80);
		wait_pirq(1'b1);
		read_check(16'h4010, 8'h00, "int_status cleared");
		report_test("interrupt", errors_before);
	endtask

	task automatic selector_test();
		int errors_before;
		errors_before = error_count;
		reg_write(16'h4032, 8'h0A); // Selector 01 with lock
		read_check(16'h4032, 8'h0A, "interface selector locked");
		reg_write(16'h4032, 8'h04);
		read_check(16'h4032, 8'h0A, "interface selector kept");
		report_test("selector lock", errors_before);
	endtask

	initial
	begin
		clock = 1'b0;
		reset_n = 1'b0;
		req = 1'b0;
		dir = 1'b0;
		addr = '0;
		wdata = '0;
		fifo_byte = '0;
		fifo_complete = 1'b0;
		fifo_empty = 1'b1;
		exec_done = 1'b0;
		error_count = 0;
		check_count = 0;
		lcg_state = 32'h5f56;
		seen_fifo_write = 1'b0;
		seen_fifo_read = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset_n = 1'b1;
		@(negedge clock);
		identity_test();
		arbitration_test();
		command_test();
		interrupt_test();
		selector_test();
		if (u_dut.u_assertions.fail_count != 0)
		begin
			$display("%0d assertion failures reported", u_dut.u_assertions.fail_count);
			error_count += int'(u_dut.u_assertions.fail_count);
		end
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== testbench/tpm_reg_space_assertions.sv ====
// TPM register space assertions
`timescale 1ns/1ps

module tpm_reg_space_assertions
(
	input logic        clock,
	input logic        reset_n,
	input logic        req_i,
	input logic        dir_i,
	input logic [15:0] addr_i,
	input logic [7:0]  locality_o,
	input logic        fifo_write_o,
	input logic        pirq_n_o,
	input logic        global_en_i
);

	int unsigned fail_count = 0; // Failed assertions so far
	logic        fifo_window;

	assign fifo_window = (addr_i[11:2] == tpm_pkg::fifo_lo_ofs[11:2]) ||
		(addr_i[11:2] == tpm_pkg::fifo_hi_ofs[11:2]);

	// At most one locality granted, and no grant change on a register cycle
	locality_onehot: assert property (@(posedge clock) disable iff (!reset_n)
		(req_i && !fifo_window) |=> ($onehot0(locality_o) && $stable(locality_o)))
		else
		begin
			fail_count++;
			$error("locality_o changed on a register cycle or has several bits set");
		end

	// FIFO writes only from the granted locality
	fifo_write_locality: assert property (@(posedge clock) disable iff (!reset_n)
		fifo_write_o |-> (req_i && !dir_i && fifo_window &&
			locality_o == (8'h01 << addr_i[15:12])))
		else
		begin
			fail_count++;
			$error("fifo_write_o fired for a locality that holds no grant");
		end

	// Interrupt line drops only after an enabled advance step
	pirq_idle_high: assert property (@(posedge clock) disable iff (!reset_n)
		$fell(pirq_n_o) |-> $past(global_en_i && (!req_i || fifo_window)))
		else
		begin
			fail_count++;
			$error("pirq_n_o went low without global enable on an advance cycle");
		end

endmodule

bind tpm_reg_space tpm_reg_space_assertions u_assertions (
	.clock        (clock),
	.reset_n      (reset_n),
	.req_i        (req_i),
	.dir_i        (dir_i),
	.addr_i       (addr_i),
	.locality_o   (locality_o),
	.fifo_write_o (fifo_write_o),
	.pirq_n_o     (pirq_n_o),
	.global_en_i  (global_en)
);

// ==== tpm_reg_space.f ====
source/tpm_pkg.sv
source/tpm_locality_arbiter.sv
source/tpm_status_fsm.sv
source/tpm_interrupt_ctrl.sv
source/tpm_reg_decode.sv
source/tpm_reg_space.sv
testbench/tpm_reg_space_assertions.sv
testbench/tb_tpm_reg_space.sv
